// File: rtl/sb_cfg.svh
// scoreboard configuration
// queue depth, port counts and data widths shared by the RTL and the testbench
`ifndef SB_CFG_SVH
`define SB_CFG_SVH

// queue depth, must stay a power of two
`define SB_NR_ENTRIES 8
// transaction id width, log2 of the depth
`define SB_ENTRY_W 3
// occupancy counter, one bit wider than the id so its msb alone means full
`define SB_CNT_W 4

`define SB_NR_WB_PORTS 2
`define SB_NR_COMMIT_PORTS 2

// general purpose register file
`define SB_REG_ADDR_W 5
`define SB_NR_REGS 32
`define SB_XLEN 32

`endif

// File: rtl/sb_pkg.sv
// scoreboard types
// functional unit encoding and the record kept per queue entry
`include "sb_cfg.svh"

package sb_pkg;

  // ------------------------------------------------------------------
  // functional units
  // ------------------------------------------------------------------
  // NONE marks instructions that need no unit, they complete on their own
  typedef enum logic [2:0] {
    NONE   = 3'd0,
    ALU    = 3'd1,
    BRANCH = 3'd2,
    LOAD   = 3'd3,
    STORE  = 3'd4,
    MULT   = 3'd5
  } fu_t;

  // ------------------------------------------------------------------
  // queue entry
  // ------------------------------------------------------------------
  typedef struct packed {
    // entry holds an in-flight instruction
    logic                          issued;
    // result has been written back (or fu is NONE)
    logic                          valid;
    // unit that executes the instruction
    fu_t                           fu;
    // destination register
    logic [`SB_REG_ADDR_W-1:0]     rd;
    // write-back data, only meaningful once valid
    logic [`SB_XLEN-1:0]           result;
  } sb_entry_t;

endpackage

// File: rtl/sb_entry_store.sv
// scoreboard entry storage
// circular queue of in-flight instructions with issue and commit pointers
// and an occupancy counter; applies issue, NONE completion, write-back,
// commit and flush to the entries in one next-state process
`timescale 1ns/100ps
`include "sb_cfg.svh"

module sb_entry_store import sb_pkg::*; (
  input  logic                                                clk_i,
  input  logic                                                rst_ni,
  // new entry from the issue handshake
  input  logic                                                issue_en_i,
  input  fu_t                                                 issue_fu_i,
  input  logic [`SB_REG_ADDR_W-1:0]                           issue_rd_i,
  // write-back ports
  input  logic [`SB_NR_WB_PORTS-1:0]                          wb_valid_i,
  input  logic [`SB_NR_WB_PORTS-1:0][`SB_ENTRY_W-1:0]         wb_trans_id_i,
  input  logic [`SB_NR_WB_PORTS-1:0][`SB_XLEN-1:0]            wb_data_i,
  // in-order retirement, port 1 only acks together with port 0
  input  logic [`SB_NR_COMMIT_PORTS-1:0]                      commit_ack_i,
  input  logic                                                flush_i,
  output sb_entry_t [`SB_NR_ENTRIES-1:0]                      entries_o,
  output logic [`SB_ENTRY_W-1:0]                              issue_ptr_o,
  output logic [`SB_NR_COMMIT_PORTS-1:0][`SB_ENTRY_W-1:0]     commit_ptr_o,
  output logic                                                full_o
);

  sb_entry_t [`SB_NR_ENTRIES-1:0]                   mem_q, mem_n;
  logic [`SB_ENTRY_W-1:0]                           issue_ptr_q, issue_ptr_n;
  logic [`SB_NR_COMMIT_PORTS-1:0][`SB_ENTRY_W-1:0]  commit_ptr_q, commit_ptr_n;
  logic [`SB_CNT_W-1:0]                             cnt_q, cnt_n;
  logic [`SB_CNT_W-1:0]                             num_commit;

  // ------------------------------------------------------------------
  // entry next state
  // ------------------------------------------------------------------
  always_comb begin : entry_update
    mem_n = mem_q;

    // new instruction at the issue pointer, result stays until write-back
    if (issue_en_i) begin
      mem_n[issue_ptr_q].issued = 1'b1;
      mem_n[issue_ptr_q].valid  = 1'b0;
      mem_n[issue_ptr_q].fu     = issue_fu_i;
      mem_n[issue_ptr_q].rd     = issue_rd_i;
    end

    // no unit to wait for, so complete one cycle after issue
    for (int i = 0; i < `SB_NR_ENTRIES; i++) begin
      if (mem_q[i].issued && (mem_q[i].fu == NONE)) begin
        mem_n[i].valid = 1'b1;
      end
    end

    // write-back only lands on issued entries
    // stale results from before a flush are dropped here
    for (int k = 0; k < `SB_NR_WB_PORTS; k++) begin
      if (wb_valid_i[k] && mem_q[wb_trans_id_i[k]].issued) begin
        mem_n[wb_trans_id_i[k]].valid  = 1'b1;
        mem_n[wb_trans_id_i[k]].result = wb_data_i[k];
      end
    end

    // retired entries become free
    for (int k = 0; k < `SB_NR_COMMIT_PORTS; k++) begin
      if (commit_ack_i[k]) begin
        mem_n[commit_ptr_q[k]].issued = 1'b0;
        mem_n[commit_ptr_q[k]].valid  = 1'b0;
      end
    end

    // flush wins over everything above
    if (flush_i) begin
      for (int i = 0; i < `SB_NR_ENTRIES; i++) begin
        mem_n[i].issued = 1'b0;
        mem_n[i].valid  = 1'b0;
      end
    end
  end

  // ------------------------------------------------------------------
  // pointers and occupancy
  // ------------------------------------------------------------------
  always_comb begin : ptr_update
    // number of acks this cycle
    num_commit = '0;
    for (int k = 0; k < `SB_NR_COMMIT_PORTS; k++) begin
      num_commit = num_commit + {{(`SB_CNT_W-1){1'b0}}, commit_ack_i[k]};
    end

    cnt_n           = cnt_q - num_commit + {{(`SB_CNT_W-1){1'b0}}, issue_en_i};
    issue_ptr_n     = issue_ptr_q + {{(`SB_ENTRY_W-1){1'b0}}, issue_en_i};
    commit_ptr_n[0] = commit_ptr_q[0] + num_commit[`SB_ENTRY_W-1:0];
    if (flush_i) begin
      cnt_n           = '0;
      issue_ptr_n     = '0;
      commit_ptr_n[0] = '0;
    end
    // further commit slots follow the oldest one
    for (int k = 1; k < `SB_NR_COMMIT_PORTS; k++) begin
      commit_ptr_n[k] = commit_ptr_n[0] + `SB_ENTRY_W'(k);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : regs
    if (!rst_ni) begin
      mem_q       <= '0;
      cnt_q       <= '0;
      issue_ptr_q <= '0;
      for (int k = 0; k < `SB_NR_COMMIT_PORTS; k++) begin
        commit_ptr_q[k] <= `SB_ENTRY_W'(k);
      end
    end else begin
      mem_q        <= mem_n;
      cnt_q        <= cnt_n;
      issue_ptr_q  <= issue_ptr_n;
      commit_ptr_q <= commit_ptr_n;
    end
  end

  assign entries_o    = mem_q;
  assign issue_ptr_o  = issue_ptr_q;
  assign commit_ptr_o = commit_ptr_q;
  // power-of-two depth, so the counter msb alone means full
  assign full_o       = cnt_q[`SB_CNT_W-1];

endmodule

// File: rtl/sb_clobber.sv
// register clobber map
// for each general purpose register reports the unit of the in-flight
// instruction that will write it, NONE when the register is free
`timescale 1ns/100ps
`include "sb_cfg.svh"

module sb_clobber import sb_pkg::*; (
  input  sb_entry_t [`SB_NR_ENTRIES-1:0]  entries_i,
  output fu_t [`SB_NR_REGS-1:0]           rd_clobber_o
);

  // per register: which entries target it
  logic [`SB_NR_REGS-1:0][`SB_NR_ENTRIES-1:0] clobber_req;

  always_comb begin : clobber_match
    clobber_req = '0;
    for (int r = 0; r < `SB_NR_REGS; r++) begin
      for (int i = 0; i < `SB_NR_ENTRIES; i++) begin
        clobber_req[r][i] = entries_i[i].issued &&
                            (entries_i[i].rd == `SB_REG_ADDR_W'(r));
      end
    end
    // x0 is hardwired, never clobbered
    clobber_req[0] = '0;
  end

  // ------------------------------------------------------------------
  // fixed priority select, lowest entry index wins
  // ------------------------------------------------------------------
  always_comb begin : clobber_sel
    for (int r = 0; r < `SB_NR_REGS; r++) begin
      rd_clobber_o[r] = NONE;
      // walk downwards so the lowest matching index is assigned last
      for (int i = `SB_NR_ENTRIES - 1; i >= 0; i--) begin
        if (clobber_req[r][i]) begin
          rd_clobber_o[r] = entries_i[i].fu;
        end
      end
    end
  end

endmodule

// File: rtl/sb_operand_fwd.sv
// operand forwarding
// register-file-like read of rs1 and rs2 from in-flight results
// write-back ports have priority over stored entries, port 0 first,
// then the lowest entry index; x0 never reports valid
`timescale 1ns/100ps
`include "sb_cfg.svh"

module sb_operand_fwd import sb_pkg::*; (
  input  sb_entry_t [`SB_NR_ENTRIES-1:0]                entries_i,
  // write-back ports, forwarded in the cycle they are strobed
  input  logic [`SB_NR_WB_PORTS-1:0]                    wb_valid_i,
  input  logic [`SB_NR_WB_PORTS-1:0][`SB_ENTRY_W-1:0]   wb_trans_id_i,
  input  logic [`SB_NR_WB_PORTS-1:0][`SB_XLEN-1:0]      wb_data_i,
  // source register addresses from the operand read stage
  input  logic [`SB_REG_ADDR_W-1:0]                     rs1_i,
  input  logic [`SB_REG_ADDR_W-1:0]                     rs2_i,
  output logic [`SB_XLEN-1:0]                           rs1_o,
  output logic                                          rs1_valid_o,
  output logic [`SB_XLEN-1:0]                           rs2_o,
  output logic                                          rs2_valid_o
);

  // source 0 is rs1, source 1 is rs2
  logic [1:0][`SB_REG_ADDR_W-1:0] rs_addr;
  logic [1:0][`SB_XLEN-1:0]       rs_data;
  logic [1:0]                     rs_hit;

  assign rs_addr[0] = rs1_i;
  assign rs_addr[1] = rs2_i;

  // ------------------------------------------------------------------
  // fixed priority search per source
  // ------------------------------------------------------------------
  always_comb begin : fwd_sel
    for (int j = 0; j < 2; j++) begin
      rs_hit[j]  = 1'b0;
      rs_data[j] = '0;

      // results being written back this cycle come first
      for (int k = 0; k < `SB_NR_WB_PORTS; k++) begin
        if (!rs_hit[j] && wb_valid_i[k] &&
            (entries_i[wb_trans_id_i[k]].rd == rs_addr[j])) begin
          rs_hit[j]  = 1'b1;
          rs_data[j] = wb_data_i[k];
        end
      end

      // then completed entries still waiting for commit
      for (int i = 0; i < `SB_NR_ENTRIES; i++) begin
        if (!rs_hit[j] && entries_i[i].issued && entries_i[i].valid &&
            (entries_i[i].rd == rs_addr[j])) begin
          rs_hit[j]  = 1'b1;
          rs_data[j] = entries_i[i].result;
        end
      end
    end
  end

  // x0 reads are never forwarded
  assign rs1_o       = rs_data[0];
  assign rs1_valid_o = rs_hit[0] & (|rs1_i);
  assign rs2_o       = rs_data[1];
  assign rs2_valid_o = rs_hit[1] & (|rs2_i);

endmodule

// File: rtl/scoreboard_top.sv
// in-order scoreboard
// tracks decoded, issued and committed instructions in an 8 entry queue,
// gates issue on full and unresolved branches, presents the two oldest
// entries to commit and provides clobber and forwarding information
`timescale 1ns/100ps
`include "sb_cfg.svh"

module scoreboard_top import sb_pkg::*; (
  input  logic                                              clk_i,
  input  logic                                              rst_ni,
  input  logic                                              flush_i,
  input  logic                                              flush_unissued_i,
  input  logic                                              unresolved_branch_i,
  output logic                                              sb_full_o,
  // decode side
  input  logic                                              decoded_valid_i,
  input  fu_t                                               decoded_fu_i,
  input  logic [`SB_REG_ADDR_W-1:0]                         decoded_rd_i,
  output logic                                              decoded_ack_o,
  // issue side
  output logic                                              issue_valid_o,
  output fu_t                                               issue_fu_o,
  output logic [`SB_REG_ADDR_W-1:0]                         issue_rd_o,
  output logic [`SB_ENTRY_W-1:0]                            issue_trans_id_o,
  input  logic                                              issue_ack_i,
  // write-back
  input  logic [`SB_NR_WB_PORTS-1:0]                        wb_valid_i,
  input  logic [`SB_NR_WB_PORTS-1:0][`SB_ENTRY_W-1:0]       wb_trans_id_i,
  input  logic [`SB_NR_WB_PORTS-1:0][`SB_XLEN-1:0]          wb_data_i,
  // commit
  output logic [`SB_NR_COMMIT_PORTS-1:0]                    commit_valid_o,
  output fu_t [`SB_NR_COMMIT_PORTS-1:0]                     commit_fu_o,
  output logic [`SB_NR_COMMIT_PORTS-1:0][`SB_REG_ADDR_W-1:0] commit_rd_o,
  output logic [`SB_NR_COMMIT_PORTS-1:0][`SB_XLEN-1:0]      commit_result_o,
  output logic [`SB_NR_COMMIT_PORTS-1:0][`SB_ENTRY_W-1:0]   commit_trans_id_o,
  input  logic [`SB_NR_COMMIT_PORTS-1:0]                    commit_ack_i,
  // clobber map and operand read
  output fu_t [`SB_NR_REGS-1:0]                             rd_clobber_o,
  input  logic [`SB_REG_ADDR_W-1:0]                         rs1_i,
  output logic [`SB_XLEN-1:0]                               rs1_o,
  output logic                                              rs1_valid_o,
  input  logic [`SB_REG_ADDR_W-1:0]                         rs2_i,
  output logic [`SB_XLEN-1:0]                               rs2_o,
  output logic                                              rs2_valid_o
);

  sb_entry_t [`SB_NR_ENTRIES-1:0]                   entries;
  logic [`SB_ENTRY_W-1:0]                           issue_ptr;
  logic [`SB_NR_COMMIT_PORTS-1:0][`SB_ENTRY_W-1:0]  commit_ptr;
  logic                                             full;
  logic                                             issue_en;

  // ------------------------------------------------------------------
  // issue handshake
  // ------------------------------------------------------------------
  // hold off issue while full or behind an unresolved branch
  assign issue_valid_o    = decoded_valid_i & ~unresolved_branch_i & ~full;
  assign decoded_ack_o    = issue_ack_i & ~full;
  // flush_unissued drops the entry but not the handshake
  assign issue_en         = decoded_valid_i & decoded_ack_o & ~flush_unissued_i;
  assign issue_fu_o       = decoded_fu_i;
  assign issue_rd_o       = decoded_rd_i;
  assign issue_trans_id_o = issue_ptr;
  assign sb_full_o        = full;

  // commit ports show the oldest entries in order
  always_comb begin : commit_ports
    for (int k = 0; k < `SB_NR_COMMIT_PORTS; k++) begin
      commit_valid_o[k]    = entries[commit_ptr[k]].valid;
      commit_fu_o[k]       = entries[commit_ptr[k]].fu;
      commit_rd_o[k]       = entries[commit_ptr[k]].rd;
      commit_result_o[k]   = entries[commit_ptr[k]].result;
      commit_trans_id_o[k] = commit_ptr[k];
    end
  end

  // ------------------------------------------------------------------
  // blocks
  // ------------------------------------------------------------------
  sb_entry_store u_store (
    .clk_i         ( clk_i         ),
    .rst_ni        ( rst_ni        ),
    .issue_en_i    ( issue_en      ),
    .issue_fu_i    ( decoded_fu_i  ),
    .issue_rd_i    ( decoded_rd_i  ),
    .wb_valid_i    ( wb_valid_i    ),
    .wb_trans_id_i ( wb_trans_id_i ),
    .wb_data_i     ( wb_data_i     ),
    .commit_ack_i  ( commit_ack_i  ),
    .flush_i       ( flush_i       ),
    .entries_o     ( entries       ),
    .issue_ptr_o   ( issue_ptr     ),
    .commit_ptr_o  ( commit_ptr    ),
    .full_o        ( full          )
  );

  sb_clobber u_clobber (
    .entries_i    ( entries      ),
    .rd_clobber_o ( rd_clobber_o )
  );

  sb_operand_fwd u_fwd (
    .entries_i     ( entries       ),
    .wb_valid_i    ( wb_valid_i    ),
    .wb_trans_id_i ( wb_trans_id_i ),
    .wb_data_i     ( wb_data_i     ),
    .rs1_i         ( rs1_i         ),
    .rs2_i         ( rs2_i         ),
    .rs1_o         ( rs1_o         ),
    .rs1_valid_o   ( rs1_valid_o   ),
    .rs2_o         ( rs2_o         ),
    .rs2_valid_o   ( rs2_valid_o   )
  );

endmodule

// File: dv/tb_scoreboard.sv
// scoreboard testbench
// random issue, write-back, commit and flush traffic from a fixed-seed LCG,
// every cycle compared against a reference model of the queue
`timescale 1ns/100ps
`include "sb_cfg.svh"

module tb_scoreboard import sb_pkg::*; ();

  localparam int CLK_PERIOD = 100;
  localparam int NE         = `SB_NR_ENTRIES;
  // cycles per test that make up the watchdog budget
  localparam int T_FILL     = 24;
  localparam int T_WB       = 80;
  localparam int T_NONE     = 40;
  localparam int T_CLOBBER  = 40;
  localparam int T_FWD      = 60;
  localparam int T_FLUSH    = 60;
  localparam int RUN_CYCLES = 4 + 1 + T_FILL + T_WB + 1 + T_NONE + T_CLOBBER + T_FWD + T_FLUSH;

  logic clk_i = 1'b0;
  logic rst_ni;
  logic flush_i;
  logic flush_unissued_i;
  logic unresolved_branch_i;
  logic sb_full_o;
  logic decoded_valid_i;
  fu_t  decoded_fu_i;
  logic [`SB_REG_ADDR_W-1:0] decoded_rd_i;
  logic decoded_ack_o;
  logic issue_valid_o;
  fu_t  issue_fu_o;
  logic [`SB_REG_ADDR_W-1:0] issue_rd_o;
  logic [`SB_ENTRY_W-1:0] issue_trans_id_o;
  logic issue_ack_i;
  logic [`SB_NR_WB_PORTS-1:0] wb_valid_i;
  logic [`SB_NR_WB_PORTS-1:0][`SB_ENTRY_W-1:0] wb_trans_id_i;
  logic [`SB_NR_WB_PORTS-1:0][`SB_XLEN-1:0] wb_data_i;
  logic [`SB_NR_COMMIT_PORTS-1:0] commit_valid_o;
  fu_t  [`SB_NR_COMMIT_PORTS-1:0] commit_fu_o;
  logic [`SB_NR_COMMIT_PORTS-1:0][`SB_REG_ADDR_W-1:0] commit_rd_o;
  logic [`SB_NR_COMMIT_PORTS-1:0][`SB_XLEN-1:0] commit_result_o;
  logic [`SB_NR_COMMIT_PORTS-1:0][`SB_ENTRY_W-1:0] commit_trans_id_o;
  logic [`SB_NR_COMMIT_PORTS-1:0] commit_ack_i;
  fu_t  [`SB_NR_REGS-1:0] rd_clobber_o;
  logic [`SB_REG_ADDR_W-1:0] rs1_i;
  logic [`SB_XLEN-1:0] rs1_o;
  logic rs1_valid_o;
  logic [`SB_REG_ADDR_W-1:0] rs2_i;
  logic [`SB_XLEN-1:0] rs2_o;
  logic rs2_valid_o;

  // reference model of the queue
  logic                      m_issued [NE];
  logic                      m_valid  [NE];
  fu_t                       m_fu     [NE];
  logic [`SB_REG_ADDR_W-1:0] m_rd     [NE];
  logic [`SB_XLEN-1:0]       m_result [NE];
  int m_iptr;
  int m_cptr;
  int m_cnt;

  // traffic mix of the running test in percent
  int k_issue;
  int k_wb;
  int k_commit;
  int k_branch;
  int k_flun;
  int k_fu_mode;
  bit k_flush;
  string test_name;
  int err_count;
  int check_count;
  int unsigned lcg_state = 71;

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  scoreboard_top DUT (.*);

  // ------------------------------------------------------------------
  // random numbers
  // ------------------------------------------------------------------
  function automatic int unsigned lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return (lcg_state >> 16) & 32'h7fff;
  endfunction

  function automatic int unsigned rand_below(input int unsigned n);
    return lcg_next() % n;
  endfunction

  function automatic bit chance(input int unsigned pct);
    return rand_below(100) < pct;
  endfunction

  function automatic logic [31:0] rand_word();
    return (lcg_next() << 17) ^ (lcg_next() << 2) ^ lcg_next();
  endfunction

  task automatic compare(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
    check_count++;
    if (actual !== expected) begin
      err_count++;
      $display("[FAIL] %s %s: expected %0h, actual %0h", test_name, name, expected, actual);
    end
  endtask

  // ------------------------------------------------------------------
  // reference model
  // ------------------------------------------------------------------
  task automatic reset_model();
    for (int i = 0; i < NE; i++) begin
      m_issued[i] = 1'b0;
      m_valid[i]  = 1'b0;
      m_fu[i]     = NONE;
      m_rd[i]     = '0;
      m_result[i] = '0;
    end
    m_iptr = 0;
    m_cptr = 0;
    m_cnt  = 0;
  endtask

  // applies the inputs sampled at this rising edge
  task automatic update_model();
    bit issue_en;
    int acks;
    int id;
    issue_en = decoded_valid_i && issue_ack_i && (m_cnt < NE) && !flush_unissued_i;
    acks = int'(commit_ack_i[0]) + int'(commit_ack_i[1]);
    // completion rules see only entries issued before this edge
    for (int i = 0; i < NE; i++) begin
      if (m_issued[i] && m_fu[i] == NONE) begin
        m_valid[i] = 1'b1;
      end
    end
    for (int k = 0; k < `SB_NR_WB_PORTS; k++) begin
      id = int'(wb_trans_id_i[k]);
      if (wb_valid_i[k] && m_issued[id]) begin
        m_valid[id]  = 1'b1;
        m_result[id] = wb_data_i[k];
      end
    end
    if (issue_en) begin
      m_issued[m_iptr] = 1'b1;
      m_valid[m_iptr]  = 1'b0;
      m_fu[m_iptr]     = decoded_fu_i;
      m_rd[m_iptr]     = decoded_rd_i;
    end
    for (int k = 0; k < `SB_NR_COMMIT_PORTS; k++) begin
      if (commit_ack_i[k]) begin
        m_issued[(m_cptr + k) % NE] = 1'b0;
        m_valid[(m_cptr + k) % NE]  = 1'b0;
      end
    end
    m_cnt  = m_cnt - acks + (issue_en ? 1 : 0);
    m_iptr = (m_iptr + (issue_en ? 1 : 0)) % NE;
    m_cptr = (m_cptr + acks) % NE;
    if (flush_i) begin
      for (int i = 0; i < NE; i++) begin
        m_issued[i] = 1'b0;
        m_valid[i]  = 1'b0;
      end
      m_cnt  = 0;
      m_iptr = 0;
      m_cptr = 0;
    end
  endtask

  // write-back ports first, port 0 before port 1, then the lowest entry
  task automatic expect_operand(input logic [`SB_REG_ADDR_W-1:0] rs, output bit hit,
                                output logic [`SB_XLEN-1:0] data);
    hit  = 1'b0;
    data = '0;
    for (int k = 0; k < `SB_NR_WB_PORTS; k++) begin
      if (!hit && wb_valid_i[k] && m_rd[wb_trans_id_i[k]] == rs) begin
        hit  = 1'b1;
        data = wb_data_i[k];
      end
    end
    for (int i = 0; i < NE; i++) begin
      if (!hit && m_issued[i] && m_valid[i] && m_rd[i] == rs) begin
        hit  = 1'b1;
        data = m_result[i];
      end
    end
    hit = hit && (rs != '0);
  endtask

  task automatic check_outputs();
    bit full_m;
    bit hit;
    int idx;
    fu_t exp_fu;
    logic [`SB_XLEN-1:0] data;
    full_m = (m_cnt >= NE);
    compare("full", 32'(full_m), 32'(sb_full_o));
    compare("issue valid", 32'(decoded_valid_i && !unresolved_branch_i && !full_m),
            32'(issue_valid_o));
    compare("decoded ack", 32'(issue_ack_i && !full_m), 32'(decoded_ack_o));
    compare("issue trans id", m_iptr, 32'(issue_trans_id_o));
    compare("issue fu", 32'(decoded_fu_i), 32'(issue_fu_o));
    compare("issue rd", 32'(decoded_rd_i), 32'(issue_rd_o));
    for (int k = 0; k < `SB_NR_COMMIT_PORTS; k++) begin
      idx = (m_cptr + k) % NE;
      compare($sformatf("commit%0d valid", k), 32'(m_valid[idx]), 32'(commit_valid_o[k]));
      compare($sformatf("commit%0d id", k), idx, 32'(commit_trans_id_o[k]));
      if (m_valid[idx]) begin
        compare($sformatf("commit%0d result", k), m_result[idx], commit_result_o[k]);
        compare($sformatf("commit%0d fu", k), 32'(m_fu[idx]), 32'(commit_fu_o[k]));
        compare($sformatf("commit%0d rd", k), 32'(m_rd[idx]), 32'(commit_rd_o[k]));
      end
    end
    // lowest-index issued writer owns the register and x0 stays free
    for (int r = 0; r < `SB_NR_REGS; r++) begin
      exp_fu = NONE;
      hit    = 1'b0;
      for (int i = 0; i < NE; i++) begin
        if (r != 0 && !hit && m_issued[i] && m_rd[i] == `SB_REG_ADDR_W'(r)) begin
          hit    = 1'b1;
          exp_fu = m_fu[i];
        end
      end
      compare($sformatf("clobber x%0d", r), 32'(exp_fu), 32'(rd_clobber_o[r]));
    end
    expect_operand(rs1_i, hit, data);
    compare("rs1 valid", 32'(hit), 32'(rs1_valid_o));
    if (hit) begin
      compare("rs1 data", data, rs1_o);
    end
    expect_operand(rs2_i, hit, data);
    compare("rs2 valid", 32'(hit), 32'(rs2_valid_o));
    if (hit) begin
      compare("rs2 data", data, rs2_o);
    end
  endtask

  // ------------------------------------------------------------------
  // stimulus
  // ------------------------------------------------------------------
  task automatic init_inputs();
    rst_ni              <= 1'b0;
    flush_i             <= 1'b0;
    flush_unissued_i    <= 1'b0;
    unresolved_branch_i <= 1'b0;
    decoded_valid_i     <= 1'b0;
    decoded_fu_i        <= NONE;
    decoded_rd_i        <= '0;
    issue_ack_i         <= 1'b0;
    wb_valid_i          <= '0;
    wb_trans_id_i       <= '0;
    wb_data_i           <= '0;
    commit_ack_i        <= '0;
    rs1_i               <= '0;
    rs2_i               <= '0;
  endtask

  // new inputs for the coming cycle chosen from the model state
  task automatic drive_stimulus();
    bit dv;
    bit br;
    logic [2:0] fu_code;
    logic [1:0] wv;
    logic [`SB_ENTRY_W-1:0] id0;
    logic [`SB_ENTRY_W-1:0] id1;
    logic a0;
    logic a1;
    dv = chance(k_issue);
    br = chance(k_branch);
    case (k_fu_mode)
      1:       fu_code = 3'd0;
      2:       fu_code = 3'(1 + rand_below(5));
      default: fu_code = 3'(rand_below(6));
    endcase
    decoded_valid_i     <= dv;
    decoded_fu_i        <= fu_t'(fu_code);
    decoded_rd_i        <= chance(20) ? 5'(rand_below(32)) : 5'(rand_below(8));
    unresolved_branch_i <= br;
    // the issue stage acks what it sees offered and now and then acks on its own
    issue_ack_i         <= (dv && !br) || chance(15);
    flush_unissued_i    <= chance(k_flun);
    flush_i             <= k_flush;
    wv[0] = chance(k_wb);
    wv[1] = chance(k_wb);
    id0   = 3'(rand_below(8));
    id1   = 3'(rand_below(8));
    if (wv[0] && id1 == id0) begin
      id1 = id1 + 3'd1;
    end
    wb_valid_i       <= wv;
    wb_trans_id_i[0] <= id0;
    wb_trans_id_i[1] <= id1;
    wb_data_i[0]     <= rand_word();
    wb_data_i[1]     <= rand_word();
    // in-order retirement of finished entries only
    a0 = m_valid[m_cptr] && chance(k_commit);
    a1 = a0 && m_valid[(m_cptr + 1) % NE] && chance(50);
    commit_ack_i <= {a1, a0};
    rs1_i <= chance(60) ? m_rd[rand_below(NE)] : 5'(rand_below(32));
    rs2_i <= chance(60) ? m_rd[rand_below(NE)] : 5'(rand_below(32));
  endtask

  task automatic run_cycles(input int n);
    repeat (n) begin
      @(posedge clk_i);
      update_model();
      drive_stimulus();
      @(negedge clk_i);
      check_outputs();
    end
  endtask

  task automatic set_knobs(input string name, input int issue, input int wb,
                           input int commit, input int branch, input int flun,
                           input int fu_mode);
    test_name = name;
    k_issue   = issue;
    k_wb      = wb;
    k_commit  = commit;
    k_branch  = branch;
    k_flun    = flun;
    k_fu_mode = fu_mode;
    k_flush   = 1'b0;
  endtask

  task automatic flush_cycle();
    k_flush = 1'b1;
    run_cycles(1);
    k_flush = 1'b0;
  endtask

  task automatic apply_reset();
    repeat (4) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    check_outputs();
  endtask

  // ------------------------------------------------------------------
  // test sequence
  // ------------------------------------------------------------------
  initial begin : main
    err_count   = 0;
    check_count = 0;
    reset_model();
    set_knobs("reset", 0, 0, 0, 0, 0, 0);
    init_inputs();
    apply_reset();

    // fill without commits while branches hold issue back now and then
    set_knobs("issue_full", 100, 0, 0, 25, 0, 2);
    run_cycles(T_FILL);
    compare("full after fill", 32'd1, 32'(sb_full_o));

    set_knobs("wb_commit", 50, 60, 70, 10, 0, 2);
    run_cycles(T_WB);

    // NONE entries must retire without any write-back
    set_knobs("none_completion", 60, 0, 60, 0, 0, 1);
    flush_cycle();
    run_cycles(T_NONE);

    set_knobs("clobber", 80, 30, 20, 0, 0, 0);
    run_cycles(T_CLOBBER);

    set_knobs("forwarding", 40, 80, 50, 0, 0, 2);
    run_cycles(T_FWD);

    set_knobs("flush", 80, 40, 30, 0, 0, 0);
    run_cycles(16);
    flush_cycle();
    k_issue  = 100;
    k_wb     = 0;
    k_commit = 0;
    run_cycles(1);
    compare("id after flush", 32'd0, 32'(issue_trans_id_o));
    for (int r = 0; r < `SB_NR_REGS; r++) begin
      compare($sformatf("clobber x%0d after flush", r), 32'(NONE), 32'(rd_clobber_o[r]));
    end
    run_cycles(1);
    compare("id after first issue", 32'd1, 32'(issue_trans_id_o));

    set_knobs("flush_unissued", 60, 40, 50, 10, 50, 0);
    run_cycles(T_FLUSH - 19);

    $display("%0d checks, %0d errors", check_count, err_count);
    if (err_count == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  initial begin : watchdog
    #((RUN_CYCLES + 100) * CLK_PERIOD);
    $display("watchdog timeout: run did not end within %0d cycles", RUN_CYCLES + 100);
    $display("Test failed");
    $finish;
  end

endmodule

// File: vlog.f
+incdir+rtl
rtl/sb_pkg.sv
rtl/sb_entry_store.sv
rtl/sb_clobber.sv
rtl/sb_operand_fwd.sv
rtl/scoreboard_top.sv
dv/tb_scoreboard.sv

// File: run.sh
#!/bin/sh
# build and run the scoreboard testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f vlog.f --top-module tb_scoreboard \
  --Mdir obj_dir -o tb_scoreboard
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/tb_scoreboard)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -q -x -F "Test completed successfully"; then
  exit 0
fi
exit 1
